/* Bender.yml */
package:
  name: ctrl_unit

export_include_dirs:
  - include

sources:
  - hdl/ctrlPkg.sv
  - hdl/instrDecoder.sv
  - hdl/stageRegs.sv
  - hdl/stallUnit.sv
  - hdl/ctrlUnit.sv
  - target: test
    files:
      - sim/tbModelPkg.sv
      - sim/ctrlUnitTb.sv

/* hdl/ctrlPkg.sv */
`include "ctrl_config.svh"

package ctrlPkg;

	//////////////////////////////
	// Instruction encodings
	//////////////////////////////

	typedef enum logic [5:0] {
		opRType  = 6'b000000,
		opRegimm = 6'b000001,
		opJ      = 6'b000010,
		opJal    = 6'b000011,
		opBeq    = 6'b000100,
		opBne    = 6'b000101,
		opBlez   = 6'b000110,
		opBgtz   = 6'b000111,
		opAddi   = 6'b001000,
		opAddiu  = 6'b001001,
		opSlti   = 6'b001010,
		opSltiu  = 6'b001011,
		opAndi   = 6'b001100,
		opOri    = 6'b001101,
		opXori   = 6'b001110,
		opLui    = 6'b001111,
		opLb     = 6'b100000,
		opLh     = 6'b100001,
		opLw     = 6'b100011,
		opLbu    = 6'b100100,
		opLhu    = 6'b100101,
		opSb     = 6'b101000,
		opSh     = 6'b101001,
		opSw     = 6'b101011
	} opcodeT;

	typedef enum logic [5:0] {
		fnSll   = 6'b000000,
		fnSrl   = 6'b000010,
		fnSra   = 6'b000011,
		fnSllv  = 6'b000100,
		fnSrlv  = 6'b000110,
		fnSrav  = 6'b000111,
		fnJr    = 6'b001000,
		fnJalr  = 6'b001001,
		fnMfhi  = 6'b010000,
		fnMthi  = 6'b010001,
		fnMflo  = 6'b010010,
		fnMtlo  = 6'b010011,
		fnMult  = 6'b011000,
		fnMultu = 6'b011001,
		fnDiv   = 6'b011010,
		fnDivu  = 6'b011011,
		fnAdd   = 6'b100000,
		fnAddu  = 6'b100001,
		fnSub   = 6'b100010,
		fnSubu  = 6'b100011,
		fnAnd   = 6'b100100,
		fnOr    = 6'b100101,
		fnXor   = 6'b100110,
		fnNor   = 6'b100111,
		fnSlt   = 6'b101010,
		fnSltu  = 6'b101011
	} funcT;

	// REGIMM branches, selected by the rt field
	typedef enum logic [4:0] {
		rtBltz = 5'b00000,
		rtBgez = 5'b00001
	} regimmT;

	//////////////////////////////
	// Control fields
	//////////////////////////////

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluSrl, aluSra, aluSll,
		aluSlt, aluSltu, aluNor, aluXor, aluPassHiLo, aluPassB
	} aluOpT;

	typedef enum logic [3:0] {
		mdNone, mdMult, mdMultu, mdMthi, mdMtlo, mdMfhi, mdMflo, mdDiv, mdDivu
	} mdOpT;

	typedef enum logic [2:0] {memWord, memByteU, memByteS, memHalfU, memHalfS} memWidthT;
	typedef enum logic [1:0] {npcSeq, npcBranchJump, npcRegister} npcSelT;
	typedef enum logic {npcBranch, npcJump} npcOpT;
	typedef enum logic [2:0] {cmpEq, cmpGez, cmpGtz, cmpLez, cmpLtz, cmpNe} cmpOpT;
	typedef enum logic [1:0] {extSign, extZero, extUpper} extOpT;
	typedef enum logic [1:0] {srcARs, srcAShamt, srcAHiLo} srcASelT;
	typedef enum logic [1:0] {srcBRt, srcBImm, srcBLink} srcBSelT;
	typedef enum logic {wdAlu, wdMem} wdSelT;

	typedef struct packed {
		logic              valid;
		npcSelT            npcSel;
		npcOpT             npcOp;
		cmpOpT             cmpOp;
		extOpT             extOp;
		srcASelT           srcASel;
		srcBSelT           srcBSel;
		aluOpT             aluOp;
		mdOpT              mdOp;
		memWidthT          memWidth;
		wdSelT             wdSel;
		logic              memRead;
		logic              memWrite;
		logic              regWrite;
		logic [`REG_W-1:0] rs;
		logic [`REG_W-1:0] rt;
		logic [`REG_W-1:0] destReg;
		logic [1:0]        tNew;
		logic [1:0]        tUseRs;
		logic [1:0]        tUseRt;
	} ctrlWordT;

endpackage

/* hdl/ctrlUnit.sv */
`include "ctrl_config.svh"

module ctrlUnit (
	input  logic               clk,
	input  logic               rstN,
	input  logic [`WORD_W-1:0] instr,
	input  logic               instrValid,
	output logic               stall,
	output ctrlPkg::ctrlWordT  exCtrl,
	output logic               wbWrite,
	output logic [`REG_W-1:0]  wbDest
);

	ctrlPkg::ctrlWordT decCtrl;
	ctrlPkg::ctrlWordT memCtrl;

	//////////////////////////////
	// Decode
	//////////////////////////////

	instrDecoder instrDecoder_inst (
		.instr      (instr),
		.instrValid (instrValid),
		.decCtrl    (decCtrl)
	);

	//////////////////////////////
	// Execute, memory, write-back
	//////////////////////////////

	stageRegs stageRegs_inst (
		.clk     (clk),
		.rstN    (rstN),
		.decCtrl (decCtrl),
		.stall   (stall),
		.exCtrl  (exCtrl),
		.memCtrl (memCtrl),
		.wbWrite (wbWrite),
		.wbDest  (wbDest)
	);

	// Hazard check against both in-flight stages
	stallUnit stallUnit_inst (
		.decCtrl (decCtrl),
		.exCtrl  (exCtrl),
		.memCtrl (memCtrl),
		.stall   (stall)
	);

endmodule

/* hdl/instrDecoder.sv */
`include "ctrl_config.svh"

module instrDecoder (
	input  logic [`WORD_W-1:0] instr,
	input  logic               instrValid,
	output ctrlPkg::ctrlWordT  decCtrl
);

	ctrlPkg::opcodeT   op;
	ctrlPkg::funcT     fn;
	ctrlPkg::regimmT   rtCode;
	logic [`REG_W-1:0] rtField;
	logic [`REG_W-1:0] rdField;
	ctrlPkg::ctrlWordT c;

	assign op      = ctrlPkg::opcodeT'(instr[`OP_HI:`OP_LO]);
	assign fn      = ctrlPkg::funcT'(instr[`FUNC_HI:`FUNC_LO]);
	assign rtField = instr[`RT_HI:`RT_LO];
	assign rdField = instr[`RD_HI:`RD_LO];
	assign rtCode  = ctrlPkg::regimmT'(rtField);

	function automatic ctrlPkg::aluOpT rTypeAlu(input ctrlPkg::funcT f);
		case (f)
			ctrlPkg::fnSll, ctrlPkg::fnSllv: return ctrlPkg::aluSll;
			ctrlPkg::fnSrl, ctrlPkg::fnSrlv: return ctrlPkg::aluSrl;
			ctrlPkg::fnSra, ctrlPkg::fnSrav: return ctrlPkg::aluSra;
			ctrlPkg::fnSub, ctrlPkg::fnSubu: return ctrlPkg::aluSub;
			ctrlPkg::fnAnd: return ctrlPkg::aluAnd;
			ctrlPkg::fnOr: return ctrlPkg::aluOr;
			ctrlPkg::fnXor: return ctrlPkg::aluXor;
			ctrlPkg::fnNor: return ctrlPkg::aluNor;
			ctrlPkg::fnSlt: return ctrlPkg::aluSlt;
			ctrlPkg::fnSltu: return ctrlPkg::aluSltu;
			default: return ctrlPkg::aluAdd;
		endcase
	endfunction

	function automatic ctrlPkg::aluOpT immAlu(input ctrlPkg::opcodeT o);
		case (o)
			ctrlPkg::opSlti: return ctrlPkg::aluSlt;
			ctrlPkg::opSltiu: return ctrlPkg::aluSltu;
			ctrlPkg::opAndi: return ctrlPkg::aluAnd;
			ctrlPkg::opOri: return ctrlPkg::aluOr;
			ctrlPkg::opXori: return ctrlPkg::aluXor;
			default: return ctrlPkg::aluAdd;
		endcase
	endfunction

	always_comb begin
		// Inert word, fields overridden per instruction
		c = '0;
		c.valid = instrValid;
		c.rs = instr[`RS_HI:`RS_LO];
		c.rt = rtField;
		c.tUseRs = `TUSE_NONE;
		c.tUseRt = `TUSE_NONE;

		case (op)
			ctrlPkg::opRType: begin
				case (fn)
					ctrlPkg::fnSll, ctrlPkg::fnSrl, ctrlPkg::fnSra,
					ctrlPkg::fnSllv, ctrlPkg::fnSrlv, ctrlPkg::fnSrav,
					ctrlPkg::fnAdd, ctrlPkg::fnAddu, ctrlPkg::fnSub, ctrlPkg::fnSubu,
					ctrlPkg::fnAnd, ctrlPkg::fnOr, ctrlPkg::fnXor, ctrlPkg::fnNor,
					ctrlPkg::fnSlt, ctrlPkg::fnSltu: begin
						// Constant shifts take shamt on port A
						if (fn inside {ctrlPkg::fnSll, ctrlPkg::fnSrl, ctrlPkg::fnSra})
							c.srcASel = ctrlPkg::srcAShamt;
						c.aluOp = rTypeAlu(fn);
						c.regWrite = 1'b1;
						c.destReg = rdField;
						c.tNew = 2'd1;
						c.tUseRs = 2'd1;
						c.tUseRt = 2'd1;
					end
					ctrlPkg::fnJr, ctrlPkg::fnJalr: begin
						c.npcSel = ctrlPkg::npcRegister;
						c.tUseRs = 2'd0;
						if (fn == ctrlPkg::fnJalr) begin
							c.srcBSel = ctrlPkg::srcBLink;
							c.aluOp = ctrlPkg::aluPassB;
							c.regWrite = 1'b1;
							c.destReg = `RA_REG;
						end
					end
					ctrlPkg::fnMult: c.mdOp = ctrlPkg::mdMult;
					ctrlPkg::fnMultu: c.mdOp = ctrlPkg::mdMultu;
					ctrlPkg::fnDiv: c.mdOp = ctrlPkg::mdDiv;
					ctrlPkg::fnDivu: c.mdOp = ctrlPkg::mdDivu;
					ctrlPkg::fnMthi: c.mdOp = ctrlPkg::mdMthi;
					ctrlPkg::fnMtlo: c.mdOp = ctrlPkg::mdMtlo;
					ctrlPkg::fnMfhi, ctrlPkg::fnMflo: begin
						c.mdOp = (fn == ctrlPkg::fnMfhi) ? ctrlPkg::mdMfhi : ctrlPkg::mdMflo;
						c.srcASel = ctrlPkg::srcAHiLo;
						c.aluOp = ctrlPkg::aluPassHiLo;
						c.regWrite = 1'b1;
						c.destReg = rdField;
					end
					default: ;
				endcase
			end

			ctrlPkg::opRegimm: begin
				if (rtCode inside {ctrlPkg::rtBgez, ctrlPkg::rtBltz}) begin
					c.npcSel = ctrlPkg::npcBranchJump;
					c.cmpOp = (rtCode == ctrlPkg::rtBgez) ? ctrlPkg::cmpGez : ctrlPkg::cmpLtz;
					c.tUseRs = 2'd0;
				end
			end

			// Loads
			ctrlPkg::opLw, ctrlPkg::opLb, ctrlPkg::opLbu, ctrlPkg::opLh, ctrlPkg::opLhu: begin
				c.srcBSel = ctrlPkg::srcBImm;
				c.memRead = 1'b1;
				case (op)
					ctrlPkg::opLb: c.memWidth = ctrlPkg::memByteS;
					ctrlPkg::opLbu: c.memWidth = ctrlPkg::memByteU;
					ctrlPkg::opLh: c.memWidth = ctrlPkg::memHalfS;
					ctrlPkg::opLhu: c.memWidth = ctrlPkg::memHalfU;
					default: c.memWidth = ctrlPkg::memWord;
				endcase
				c.wdSel = ctrlPkg::wdMem;
				c.regWrite = 1'b1;
				c.destReg = rtField;
				c.tNew = 2'd2;
				c.tUseRs = 2'd1;
			end

			// Stores
			ctrlPkg::opSw, ctrlPkg::opSb, ctrlPkg::opSh: begin
				c.srcBSel = ctrlPkg::srcBImm;
				c.memWrite = 1'b1;
				if (op == ctrlPkg::opSb)
					c.memWidth = ctrlPkg::memByteU;
				else if (op == ctrlPkg::opSh)
					c.memWidth = ctrlPkg::memHalfU;
				c.tUseRs = 2'd1;
				c.tUseRt = 2'd1;
			end

			ctrlPkg::opSlti, ctrlPkg::opSltiu, ctrlPkg::opAndi, ctrlPkg::opOri,
			ctrlPkg::opXori, ctrlPkg::opLui, ctrlPkg::opAddi, ctrlPkg::opAddiu: begin
				if (op == ctrlPkg::opLui) begin
					c.extOp = ctrlPkg::extUpper;
					c.aluOp = ctrlPkg::aluPassB;
				end else begin
					c.extOp = (op inside {ctrlPkg::opAddi, ctrlPkg::opAddiu}) ?
						ctrlPkg::extSign : ctrlPkg::extZero;
					c.aluOp = immAlu(op);
				end
				c.srcBSel = ctrlPkg::srcBImm;
				c.regWrite = 1'b1;
				c.destReg = rtField;
				c.tNew = 2'd1;
				c.tUseRs = 2'd1;
			end

			ctrlPkg::opBeq, ctrlPkg::opBne, ctrlPkg::opBgtz, ctrlPkg::opBlez: begin
				c.npcSel = ctrlPkg::npcBranchJump;
				case (op)
					ctrlPkg::opBne: c.cmpOp = ctrlPkg::cmpNe;
					ctrlPkg::opBgtz: c.cmpOp = ctrlPkg::cmpGtz;
					ctrlPkg::opBlez: c.cmpOp = ctrlPkg::cmpLez;
					default: c.cmpOp = ctrlPkg::cmpEq;
				endcase
				c.tUseRs = 2'd0;
				c.tUseRt = 2'd0;
			end

			ctrlPkg::opJ, ctrlPkg::opJal: begin
				c.npcSel = ctrlPkg::npcBranchJump;
				c.npcOp = ctrlPkg::npcJump;
				if (op == ctrlPkg::opJal) begin
					c.srcBSel = ctrlPkg::srcBLink;
					c.aluOp = ctrlPkg::aluPassB;
					c.regWrite = 1'b1;
					c.destReg = `RA_REG;
				end
			end

			default: ;
		endcase
	end

	assign decCtrl = c;

endmodule

/* hdl/stageRegs.sv */
`include "ctrl_config.svh"

module stageRegs (
	input  logic              clk,
	input  logic              rstN,
	input  ctrlPkg::ctrlWordT decCtrl,
	input  logic              stall,
	output ctrlPkg::ctrlWordT exCtrl,
	output ctrlPkg::ctrlWordT memCtrl,
	output logic              wbWrite,
	output logic [`REG_W-1:0] wbDest
);

	ctrlPkg::ctrlWordT memNext;

	// One cycle closer to result and floored at zero
	always_comb begin
		memNext = exCtrl;
		if (exCtrl.tNew != 2'd0)
			memNext.tNew = exCtrl.tNew - 2'd1;
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			exCtrl <= '0;
			memCtrl <= '0;
			wbWrite <= 1'b0;
			wbDest <= '0;
		end else begin
			// Bubble on stall or empty decode slot
			if (stall || !decCtrl.valid)
				exCtrl <= '0;
			else
				exCtrl <= decCtrl;
			memCtrl <= memNext;
			wbWrite <= memCtrl.valid && memCtrl.regWrite;
			wbDest <= memCtrl.destReg;
		end
	end

	//////////////////////////////
	// Assertions
	//////////////////////////////

	// Stalled instruction waits in decode while a bubble goes down the pipe
	stallBubble: assert property (
		@(posedge clk) disable iff (!rstN)
		stall |=> !exCtrl.valid && $stable(decCtrl)
	) else $error("stall did not hold decode or insert a bubble into execute");

	wbAfterReset: assert property (
		@(posedge clk) disable iff (!rstN)
		$rose(rstN) |-> !wbWrite [*3]
	) else $error("write-back fired within three edges of reset");

	// Stall only ever holds a real instruction
	stallNeedsValid: assert property (
		@(posedge clk) disable iff (!rstN)
		!decCtrl.valid |-> !stall
	) else $error("stall raised with an empty decode slot");

endmodule

/* hdl/stallUnit.sv */
`include "ctrl_config.svh"

module stallUnit (
	input  ctrlPkg::ctrlWordT decCtrl,
	input  ctrlPkg::ctrlWordT exCtrl,
	input  ctrlPkg::ctrlWordT memCtrl,
	output logic              stall
);

	logic rsEx;
	logic rsMem;
	logic rtEx;
	logic rtMem;

	// Producer in stage will not have the value by the time it is read
	function automatic logic hazard(
		input logic [`REG_W-1:0] srcReg,
		input logic [1:0]        tUse,
		input ctrlPkg::ctrlWordT stage
	);
		return (tUse != `TUSE_NONE) &&
			(srcReg != '0) &&
			stage.valid &&
			stage.regWrite &&
			(stage.destReg == srcReg) &&
			(stage.tNew > tUse);
	endfunction

	assign rsEx  = hazard(decCtrl.rs, decCtrl.tUseRs, exCtrl);
	assign rsMem = hazard(decCtrl.rs, decCtrl.tUseRs, memCtrl);
	assign rtEx  = hazard(decCtrl.rt, decCtrl.tUseRt, exCtrl);
	assign rtMem = hazard(decCtrl.rt, decCtrl.tUseRt, memCtrl);

	assign stall = decCtrl.valid && (rsEx || rsMem || rtEx || rtMem);

endmodule

/* include/ctrl_config.svh */
`ifndef CTRL_CONFIG_SVH
`define CTRL_CONFIG_SVH

// Instruction word
`define WORD_W 32

// Field positions
`define OP_HI 31
`define OP_LO 26
`define RS_HI 25
`define RS_LO 21
`define RT_HI 20
`define RT_LO 16
`define RD_HI 15
`define RD_LO 11
`define FUNC_HI 5
`define FUNC_LO 0

// Register file index
`define REG_W 5
`define RA_REG 5'd31

// tUse value for an operand that is never read
`define TUSE_NONE 2'd3

`endif

/* sim/ctrlUnitTb.sv */
`include "ctrl_config.svh"

module ctrlUnitTb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 3;
	localparam int NUM_INSTR = 3000;
	localparam int TIMEOUT_NS = (NUM_INSTR + RESET_CYCLES) * CLK_PERIOD * 4;

	logic clk = 1'b0;
	logic rstN;
	logic [`WORD_W-1:0] instr;
	logic instrValid;
	logic stall;
	ctrlPkg::ctrlWordT exCtrl;
	logic wbWrite;
	logic [`REG_W-1:0] wbDest;

	// Model state
	ctrlPkg::ctrlWordT decModel;
	ctrlPkg::ctrlWordT exModel;
	ctrlPkg::ctrlWordT memModel;
	logic stallModel;
	logic wbWriteModel;
	logic [`REG_W-1:0] wbDestModel;
	int accepted;
	int quiet;
	int loadUseStalls;
	int branchStalls;

	ctrlUnit ctrlUnit_inst (
		.clk        (clk),
		.rstN       (rstN),
		.instr      (instr),
		.instrValid (instrValid),
		.stall      (stall),
		.exCtrl     (exCtrl),
		.wbWrite    (wbWrite),
		.wbDest     (wbDest)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic checkValue(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp)
			abortRun($sformatf("error: %s got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	initial begin
		#(TIMEOUT_NS);
		abortRun("watchdog expired before all instructions were accepted");
	end

	initial begin
		void'($urandom(58807));
		rstN = 1'b0;
		instr = '0;
		instrValid = 1'b0;
		exModel = '0;
		memModel = '0;
		wbWriteModel = 1'b0;
		wbDestModel = '0;
		accepted = 0;
		quiet = 0;
		loadUseStalls = 0;
		branchStalls = 0;
		repeat (RESET_CYCLES) @(posedge clk);
		#5;
		rstN = 1'b1;
		#1;

		//////////////////////////////
		// State right after reset
		//////////////////////////////
		checkValue("stall", stall, 1'b0);
		checkValue("exCtrl.valid", exCtrl.valid, 1'b0);
		checkValue("exCtrl.regWrite", exCtrl.regWrite, 1'b0);
		checkValue("exCtrl.memRead", exCtrl.memRead, 1'b0);
		checkValue("exCtrl.memWrite", exCtrl.memWrite, 1'b0);
		checkValue("wbWrite", wbWrite, 1'b0);
		decModel = tbModelPkg::refDecode(instr, instrValid);
		stallModel = 1'b0;

		while (accepted < NUM_INSTR || quiet < 4) begin
			@(posedge clk);
			#5;
			// Advance the model by the edge just taken
			wbWriteModel = memModel.valid && memModel.regWrite;
			wbDestModel = memModel.destReg;
			memModel = tbModelPkg::toMem(exModel);
			if (decModel.valid && !stallModel) begin
				exModel = decModel;
				accepted++;
			end else begin
				exModel = '0;
			end
			checkValue("exCtrl", exCtrl, exModel);
			checkValue("wbWrite", wbWrite, wbWriteModel);
			checkValue("wbDest", wbDest, wbDestModel);

			// Held instruction stays on the inputs while stalled
			if (accepted >= NUM_INSTR) begin
				instrValid = 1'b0;
				quiet++;
			end else if (!stallModel) begin
				instrValid = ($urandom_range(7) != 0);
				instr = tbModelPkg::randInstr();
			end
			#1;
			decModel = tbModelPkg::refDecode(instr, instrValid);
			stallModel = tbModelPkg::refStall(decModel, exModel, memModel);
			if (stallModel && exModel.memRead)
				loadUseStalls++;
			if (stallModel && exModel.regWrite && !exModel.memRead &&
					decModel.npcSel != ctrlPkg::npcSeq)
				branchStalls++;
			checkValue("stall", stall, stallModel);
		end

		$display("%0d accepted, %0d load-use stalls, %0d branch stalls",
			accepted, loadUseStalls, branchStalls);
		if (loadUseStalls == 0 || branchStalls == 0) begin
			abortRun("load-use or ALU-then-branch stalls were never exercised");
		end else begin
			$display("TEST PASSED");
			$finish;
		end
	end

endmodule

/* sim/tbModelPkg.sv */
`include "ctrl_config.svh"

package tbModelPkg;

	localparam logic [5:0] LEGAL_OPS [24] = '{
		6'h00, 6'h01, 6'h02, 6'h03, 6'h04, 6'h05, 6'h06, 6'h07,
		6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f,
		6'h20, 6'h21, 6'h23, 6'h24, 6'h25, 6'h28, 6'h29, 6'h2b
	};

	localparam logic [5:0] LEGAL_FUNCS [26] = '{
		6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07, 6'h08, 6'h09, 6'h10,
		6'h11, 6'h12, 6'h13, 6'h18, 6'h19, 6'h1a, 6'h1b, 6'h20, 6'h21,
		6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b
	};

	//////////////////////////////
	// Reference decode
	//////////////////////////////

	function automatic ctrlPkg::ctrlWordT refDecode(input logic [`WORD_W-1:0] w, input logic v);
		ctrlPkg::ctrlWordT c;
		logic [5:0] op;
		logic [5:0] fn;
		op = w[`OP_HI:`OP_LO];
		fn = w[`FUNC_HI:`FUNC_LO];
		c = '0;
		c.valid = v;
		c.rs = w[`RS_HI:`RS_LO];
		c.rt = w[`RT_HI:`RT_LO];
		c.tUseRs = `TUSE_NONE;
		c.tUseRt = `TUSE_NONE;
		if (op == 6'h00) begin
			case (fn)
				6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07, 6'h20, 6'h21,
				6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b: begin
					c.regWrite = 1'b1;
					c.destReg = w[`RD_HI:`RD_LO];
					c.tNew = 2'd1;
					c.tUseRs = 2'd1;
					c.tUseRt = 2'd1;
					if (fn < 6'h04)
						c.srcASel = ctrlPkg::srcAShamt;
					case (fn)
						6'h00, 6'h04: c.aluOp = ctrlPkg::aluSll;
						6'h02, 6'h06: c.aluOp = ctrlPkg::aluSrl;
						6'h03, 6'h07: c.aluOp = ctrlPkg::aluSra;
						6'h22, 6'h23: c.aluOp = ctrlPkg::aluSub;
						6'h24: c.aluOp = ctrlPkg::aluAnd;
						6'h25: c.aluOp = ctrlPkg::aluOr;
						6'h26: c.aluOp = ctrlPkg::aluXor;
						6'h27: c.aluOp = ctrlPkg::aluNor;
						6'h2a: c.aluOp = ctrlPkg::aluSlt;
						6'h2b: c.aluOp = ctrlPkg::aluSltu;
						default: c.aluOp = ctrlPkg::aluAdd;
					endcase
				end
				6'h08, 6'h09: begin
					c.npcSel = ctrlPkg::npcRegister;
					c.tUseRs = 2'd0;
					// jalr links through port B
					if (fn[0]) begin
						c.srcBSel = ctrlPkg::srcBLink;
						c.aluOp = ctrlPkg::aluPassB;
						c.regWrite = 1'b1;
						c.destReg = `RA_REG;
					end
				end
				6'h18: c.mdOp = ctrlPkg::mdMult;
				6'h19: c.mdOp = ctrlPkg::mdMultu;
				6'h1a: c.mdOp = ctrlPkg::mdDiv;
				6'h1b: c.mdOp = ctrlPkg::mdDivu;
				6'h11: c.mdOp = ctrlPkg::mdMthi;
				6'h13: c.mdOp = ctrlPkg::mdMtlo;
				6'h10, 6'h12: begin
					c.mdOp = fn[1] ? ctrlPkg::mdMflo : ctrlPkg::mdMfhi;
					c.srcASel = ctrlPkg::srcAHiLo;
					c.aluOp = ctrlPkg::aluPassHiLo;
					c.regWrite = 1'b1;
					c.destReg = w[`RD_HI:`RD_LO];
				end
				default: ;
			endcase
		end else begin
			case (op)
				6'h01: begin
					if (w[`RT_HI:`RT_LO] < 5'd2) begin
						c.npcSel = ctrlPkg::npcBranchJump;
						c.cmpOp = w[`RT_LO] ? ctrlPkg::cmpGez : ctrlPkg::cmpLtz;
						c.tUseRs = 2'd0;
					end
				end
				6'h20, 6'h21, 6'h23, 6'h24, 6'h25: begin
					c.srcBSel = ctrlPkg::srcBImm;
					c.memRead = 1'b1;
					c.wdSel = ctrlPkg::wdMem;
					c.regWrite = 1'b1;
					c.destReg = w[`RT_HI:`RT_LO];
					c.tNew = 2'd2;
					c.tUseRs = 2'd1;
					case (op)
						6'h20: c.memWidth = ctrlPkg::memByteS;
						6'h21: c.memWidth = ctrlPkg::memHalfS;
						6'h24: c.memWidth = ctrlPkg::memByteU;
						6'h25: c.memWidth = ctrlPkg::memHalfU;
						default: c.memWidth = ctrlPkg::memWord;
					endcase
				end
				6'h28, 6'h29, 6'h2b: begin
					c.srcBSel = ctrlPkg::srcBImm;
					c.memWrite = 1'b1;
					c.tUseRs = 2'd1;
					c.tUseRt = 2'd1;
					if (op == 6'h28)
						c.memWidth = ctrlPkg::memByteU;
					else if (op == 6'h29)
						c.memWidth = ctrlPkg::memHalfU;
				end
				6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f: begin
					c.srcBSel = ctrlPkg::srcBImm;
					c.regWrite = 1'b1;
					c.destReg = w[`RT_HI:`RT_LO];
					c.tNew = 2'd1;
					c.tUseRs = 2'd1;
					if (op > 6'h09)
						c.extOp = ctrlPkg::extZero;
					case (op)
						6'h0a: c.aluOp = ctrlPkg::aluSlt;
						6'h0b: c.aluOp = ctrlPkg::aluSltu;
						6'h0c: c.aluOp = ctrlPkg::aluAnd;
						6'h0d: c.aluOp = ctrlPkg::aluOr;
						6'h0e: c.aluOp = ctrlPkg::aluXor;
						6'h0f: begin
							c.extOp = ctrlPkg::extUpper;
							c.aluOp = ctrlPkg::aluPassB;
						end
						default: c.aluOp = ctrlPkg::aluAdd;
					endcase
				end
				6'h04, 6'h05, 6'h06, 6'h07: begin
					c.npcSel = ctrlPkg::npcBranchJump;
					c.tUseRs = 2'd0;
					c.tUseRt = 2'd0;
					case (op)
						6'h05: c.cmpOp = ctrlPkg::cmpNe;
						6'h06: c.cmpOp = ctrlPkg::cmpLez;
						6'h07: c.cmpOp = ctrlPkg::cmpGtz;
						default: c.cmpOp = ctrlPkg::cmpEq;
					endcase
				end
				6'h02, 6'h03: begin
					c.npcSel = ctrlPkg::npcBranchJump;
					c.npcOp = ctrlPkg::npcJump;
					if (op[0]) begin
						c.srcBSel = ctrlPkg::srcBLink;
						c.aluOp = ctrlPkg::aluPassB;
						c.regWrite = 1'b1;
						c.destReg = `RA_REG;
					end
				end
				default: ;
			endcase
		end
		return c;
	endfunction

	//////////////////////////////
	// Pipeline model
	//////////////////////////////

	function automatic logic refStall(
		input ctrlPkg::ctrlWordT d,
		input ctrlPkg::ctrlWordT ex,
		input ctrlPkg::ctrlWordT mem
	);
		ctrlPkg::ctrlWordT st [2];
		logic [`REG_W-1:0] src [2];
		logic [1:0] useT [2];
		logic hit;
		st[0] = ex;
		st[1] = mem;
		src[0] = d.rs;
		src[1] = d.rt;
		useT[0] = d.tUseRs;
		useT[1] = d.tUseRt;
		hit = 1'b0;
		for (int i = 0; i < 2; i++) begin
			for (int j = 0; j < 2; j++) begin
				if (useT[i] != `TUSE_NONE && src[i] != '0 && st[j].valid && st[j].regWrite &&
						st[j].destReg == src[i] && st[j].tNew > useT[i])
					hit = 1'b1;
			end
		end
		return d.valid && hit;
	endfunction

	// Execute word as seen one stage later
	function automatic ctrlPkg::ctrlWordT toMem(input ctrlPkg::ctrlWordT ex);
		ctrlPkg::ctrlWordT m;
		m = ex;
		m.tNew = (ex.tNew == 2'd0) ? 2'd0 : ex.tNew - 2'd1;
		return m;
	endfunction

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	// Small register pool keeps hazards frequent
	function automatic logic [`REG_W-1:0] pickReg();
		case ($urandom_range(3))
			0: return 5'd0;
			1: return 5'd1;
			2: return 5'd2;
			default: return 5'd31;
		endcase
	endfunction

	function automatic logic [`WORD_W-1:0] randInstr();
		logic [`WORD_W-1:0] w;
		w = $urandom();
		if ($urandom_range(7) == 0)
			return w;
		if ($urandom_range(2) == 0)
			w[`OP_HI:`OP_LO] = 6'h00;
		else
			w[`OP_HI:`OP_LO] = LEGAL_OPS[$urandom_range(23)];
		w[`RS_HI:`RS_LO] = pickReg();
		w[`RD_HI:`RD_LO] = pickReg();
		// rt of 2 is an unknown REGIMM code
		if (w[`OP_HI:`OP_LO] == 6'h01)
			w[`RT_HI:`RT_LO] = 5'($urandom_range(2));
		else
			w[`RT_HI:`RT_LO] = pickReg();
		if (w[`OP_HI:`OP_LO] == 6'h00 && $urandom_range(9) != 0)
			w[`FUNC_HI:`FUNC_LO] = LEGAL_FUNCS[$urandom_range(25)];
		return w;
	endfunction

endpackage

/* src.f */
+incdir+include
hdl/ctrlPkg.sv
hdl/instrDecoder.sv
hdl/stageRegs.sv
hdl/stallUnit.sv
hdl/ctrlUnit.sv
sim/tbModelPkg.sv
sim/ctrlUnitTb.sv
